//--- vlog.f
hdl/nocPkg.sv
hdl/arbPkg.sv
hdl/packetTimer.sv
hdl/roundRobinArbiter.sv
hdl/flitMux.sv
hdl/outputChannel.sv
sim/outputChannel_checker.sv
sim/outputChannelTb.sv

//--- Makefile
# Verilator build and run for the output channel testbench.

SRCS := $(shell cat vlog.f)
BIN  := obj_dir/VoutputChannelTb

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes.
$(BIN): vlog.f $(SRCS)
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module outputChannelTb -Mdir obj_dir

# The assertion error limit is raised so the testbench can print its summary.
run: $(BIN)
	./$(BIN) +verilator+error+limit+100 | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/outputChannelTb.sv
`timescale 1ns/100ps

module outputChannelTb
  import nocPkg::*;
  import arbPkg::*;
();

  localparam int NumTests    = 7;
  localparam int ResetCycles = 8;
  localparam int QuietCycles = 2;
  localparam int Margin      = 50;

  logic      clk;
  logic      rst;
  portIn_t   portL;
  portIn_t   portN;
  portIn_t   portE;
  portIn_t   portW;
  portIn_t   portS;
  arbState_e grant;
  flit_t     outFlit;

  // Stimulus table. Mask bit p belongs to port p, so masks read S W E N L.
  string       testName  [NumTests];
  logic [4:0]  reqMask   [NumTests];
  logic [4:0]  dropMask  [NumTests];
  logic [11:0] headLen   [NumTests][NumPorts];
  int          rowCycles [NumTests];
  int          numRows;

  portIn_t drv     [NumPorts];
  portIn_t applied [NumPorts];
  logic    appliedRst;

  // Reference model, owner is -1 while the channel is idle.
  int          owner;
  logic [11:0] mLimit [NumPorts];
  logic [11:0] mCount [NumPorts];
  flit_t       mOut;
  arbState_e   grantOfPort [NumPorts] = '{GrantL, GrantN, GrantE, GrantW, GrantS};

  int          checkCount;
  int          errorCount;
  int          cycleLimit;
  int          cycles;

  outputChannel i_dut (
    .clk     (clk),
    .rst     (rst),
    .portL   (portL),
    .portN   (portN),
    .portE   (portE),
    .portW   (portW),
    .portS   (portS),
    .grant   (grant),
    .outFlit (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table, model and compare tasks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic addRow(
    input string       name,
    input logic [4:0]  req,
    input logic [11:0] lenL,
    input logic [11:0] lenN,
    input logic [11:0] lenE,
    input logic [11:0] lenW,
    input logic [11:0] lenS,
    input int          rowLen,
    input logic [4:0]  drop
  );
    testName[numRows]   = name;
    reqMask[numRows]    = req;
    headLen[numRows][0] = lenL;
    headLen[numRows][1] = lenN;
    headLen[numRows][2] = lenE;
    headLen[numRows][3] = lenW;
    headLen[numRows][4] = lenS;
    rowCycles[numRows]  = rowLen;
    dropMask[numRows]   = drop;
    numRows++;
  endtask

  // Quiet cycles open each row, then one head flit, then body flits.
  task automatic buildDrive(input int t, input int c);
    logic active;
    for (int p = 0; p < NumPorts; p++)
    begin
      active = reqMask[t][p] && (c >= QuietCycles)
               && !(dropMask[t][p] && (c >= rowCycles[t] / 2));
      drv[p].req = active;
      if (!active)
        drv[p].flit = IdleFlit;
      else if (c == QuietCycles)
        drv[p].flit = '{flitId: FlitHead, length: headLen[t][p], payload: 16'($urandom)};
      else
        drv[p].flit = '{flitId: FlitBody, length: 12'd0, payload: 16'($urandom)};
    end
  endtask

  // Advances the model across one edge, using what the DUT sampled there.
  task automatic updateModel();
    int nextOwner;
    int run;
    int p;
    nextOwner = -1;
    run       = -1;
    if (appliedRst)
    begin
      owner = -1;
      mOut  = IdleFlit;
      for (int q = 0; q < NumPorts; q++)
      begin
        mLimit[q] = '0;
        mCount[q] = '0;
      end
    end
    else
    begin
      if (owner >= 0 && applied[owner].req && mCount[owner] != mLimit[owner])
      begin
        nextOwner = owner;
        run       = owner;
      end
      else
      begin
        // Search starts after the owner and ends on it. From idle it starts at L.
        for (int k = 1; k <= NumPorts; k++)
        begin
          p = (owner + k) % NumPorts;
          if (nextOwner < 0 && applied[p].req)
            nextOwner = p;
        end
      end
      mOut = (owner >= 0) ? applied[owner].flit : IdleFlit;
      for (int q = 0; q < NumPorts; q++)
      begin
        if (applied[q].flit.flitId == FlitHead)
          mLimit[q] = applied[q].flit.length;
        mCount[q] = (q == run) ? mCount[q] + 12'd1 : 12'd0;
      end
      owner = nextOwner;
    end
  endtask

  task automatic checkGrant(input arbState_e expected, input arbState_e actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error at %0d ns: grant expected %s (%b) got %s (%b)",
               $time, expected.name(), expected, actual.name(), actual);
    end
  endtask

  task automatic checkFlit(input flit_t expected, input flit_t actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error at %0d ns: outFlit expected %h got %h", $time, expected, actual);
    end
  endtask

  task automatic stepCycle(input logic rstVal);
    @(posedge clk);
    updateModel();
    rst   <= rstVal;
    portL <= drv[PortL];
    portN <= drv[PortN];
    portE <= drv[PortE];
    portW <= drv[PortW];
    portS <= drv[PortS];
    appliedRst = rstVal;
    for (int p = 0; p < NumPorts; p++)
      applied[p] = drv[p];
    @(negedge clk);
    checkGrant((owner < 0) ? ArbIdle : grantOfPort[owner], grant);
    checkFlit(mOut, outFlit);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    int errAtStart;
    void'($urandom(32'h107));
    checkCount = 0;
    errorCount = 0;
    numRows    = 0;
    rst        = 1'b1;
    for (int p = 0; p < NumPorts; p++)
    begin
      drv[p]     = '{req: 1'b0, flit: IdleFlit};
      applied[p] = drv[p];
    end
    portL      = drv[PortL];
    portN      = drv[PortN];
    portE      = drv[PortE];
    portW      = drv[PortW];
    portS      = drv[PortS];
    appliedRst = 1'b1;
    owner      = -1;
    mOut       = IdleFlit;

    //     name             mask      L       N       E       W       S     cyc  drop
    addRow("reset idle",    5'b00000, 12'd0, 12'd0,  12'd0, 12'd0, 12'd0,   6, 5'b00000);
    addRow("priority",      5'b10110, 12'd0, 12'd2,  12'd1, 12'd0, 12'd0,  16, 5'b00000);
    addRow("packet hold",   5'b11000, 12'd0, 12'd0,  12'd0, 12'd5, 12'd0,  16, 5'b00000);
    addRow("rotation",      5'b11111, 12'd1, 12'd2,  12'd3, 12'd0, 12'd2,  34, 5'b00000);
    addRow("drop to next",  5'b00101, 12'd8, 12'd0,  12'd2, 12'd0, 12'd0,  18, 5'b00001);
    addRow("drop to idle",  5'b10000, 12'd0, 12'd0,  12'd0, 12'd0, 12'd10, 14, 5'b10000);
    addRow("mixed lengths", 5'b01011, 12'd0, 12'd4,  12'd0, 12'd2, 12'd0,  24, 5'b00000);

    cycleLimit = ResetCycles + Margin;
    for (int t = 0; t < numRows; t++)
      cycleLimit += rowCycles[t];

    repeat (ResetCycles) stepCycle(1'b1);

    for (int t = 0; t < numRows; t++)
    begin
      errAtStart = errorCount;
      for (int c = 0; c < rowCycles[t]; c++)
      begin
        buildDrive(t, c);
        stepCycle(1'b0);
      end
      $display("Test %0d %s: %0d cycles, %0d mismatches",
               t + 1, testName[t], rowCycles[t], errorCount - errAtStart);
    end

    $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
             numRows, checkCount, errorCount, i_dut.arb.chk.failCount);
    if (errorCount == 0 && i_dut.arb.chk.failCount == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Cycle limit for the whole run.
  initial
  begin
    @(posedge clk);
    cycles = 1;
    while (cycles < cycleLimit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- sim/outputChannel_checker.sv
`timescale 1ns/100ps

module arbChecker
  import nocPkg::*;
  import arbPkg::*;
(
  input logic      clk,
  input logic      rst,
  input portVec_t  reqs,
  input portVec_t  runTimer,
  input flit_t     flitL,
  input flit_t     flitN,
  input flit_t     flitE,
  input flit_t     flitW,
  input flit_t     flitS,
  input arbState_e grant
);

  int unsigned failCount = 0;

  flit_t       flits [NumPorts];
  logic [11:0] limits [NumPorts];
  logic [11:0] curLimit;
  logic [12:0] tenureLen;
  logic [4:0]  reqBits;

  assign flits[0] = flitL;
  assign flits[1] = flitN;
  assign flits[2] = flitE;
  assign flits[3] = flitW;
  assign flits[4] = flitS;

  // Same bit order as the one-hot grant above its idle bit.
  assign reqBits = {reqs.s, reqs.w, reqs.e, reqs.n, reqs.l};

  // Cycles of the current grant tenure, limits tracked from head flits.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tenureLen <= '0;
      for (int p = 0; p < NumPorts; p++)
        limits[p] <= '0;
    end
    else
    begin
      for (int p = 0; p < NumPorts; p++)
        if (flits[p].flitId == FlitHead)
          limits[p] <= flits[p].length;
      tenureLen <= (runTimer != '0) ? tenureLen + 13'd1 : 13'd1;
    end
  end

  always_comb
  begin
    case (grant)
      GrantL:  curLimit = limits[0];
      GrantN:  curLimit = limits[1];
      GrantE:  curLimit = limits[2];
      GrantW:  curLimit = limits[3];
      GrantS:  curLimit = limits[4];
      default: curLimit = '0;
    endcase
  end

  legalGrant: assert property (@(posedge clk) disable iff (rst)
    grant inside {ArbIdle, GrantL, GrantN, GrantE, GrantW, GrantS})
    else
    begin
      failCount++;
      $error("grant holds an illegal value %b", grant);
    end

  grantFromReq: assert property (@(posedge clk) disable iff (rst)
    ($past(grant) == ArbIdle && grant != ArbIdle) |-> ((grant[5:1] & $past(reqBits)) != '0))
    else
    begin
      failCount++;
      $error("grant %b left idle for a port that did not request", grant);
    end

  holdBound: assert property (@(posedge clk) disable iff (rst)
    (grant != ArbIdle) |-> (tenureLen <= {1'b0, curLimit} + 13'd1))
    else
    begin
      failCount++;
      $error("grant %b held %0d cycles over a limit of %0d", grant, tenureLen, curLimit);
    end

endmodule

bind roundRobinArbiter arbChecker chk (
  .clk      (clk),
  .rst      (rst),
  .reqs     (reqs),
  .runTimer (runTimer),
  .flitL    (flitL),
  .flitN    (flitN),
  .flitE    (flitE),
  .flitW    (flitW),
  .flitS    (flitS),
  .grant    (grant)
);

//--- hdl/outputChannel.sv
`timescale 1ns/100ps

module outputChannel
  import nocPkg::*;
  import arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portIn_t   portL,
  input  portIn_t   portN,
  input  portIn_t   portE,
  input  portIn_t   portW,
  input  portIn_t   portS,
  output arbState_e grant,
  output flit_t     outFlit
);

  portVec_t   reqs;
  portFlits_t flits;

  assign reqs = '{
    l: portL.req,
    n: portN.req,
    e: portE.req,
    w: portW.req,
    s: portS.req
  };

  // Element order follows portIdx_e, South in the top slot.
  assign flits = {portS.flit, portW.flit, portE.flit, portN.flit, portL.flit};

  roundRobinArbiter arb (
    .clk   (clk),
    .rst   (rst),
    .reqs  (reqs),
    .flitL (portL.flit),
    .flitN (portN.flit),
    .flitE (portE.flit),
    .flitW (portW.flit),
    .flitS (portS.flit),
    .grant (grant)
  );

  flitMux mux (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .flits   (flits),
    .outFlit (outFlit)
  );

endmodule

//--- hdl/flitMux.sv
`timescale 1ns/100ps

module flitMux
  import nocPkg::*;
  import arbPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  arbState_e  grant,
  input  portFlits_t flits,
  output flit_t      outFlit
);

  portIdx_e sel;
  logic     granted;

  // One-hot grant to port index.
  always_comb
  begin
    sel     = PortL;
    granted = 1'b1;
    case (grant)
      GrantL: sel = PortL;
      GrantN: sel = PortN;
      GrantE: sel = PortE;
      GrantW: sel = PortW;
      GrantS: sel = PortS;
      default:
        granted = 1'b0;
    endcase
  end

  // An idle channel sends the idle flit, never the last one again.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit <= IdleFlit;
    end
    else if (granted)
    begin
      outFlit <= flits[sel];
    end
    else
    begin
      outFlit <= IdleFlit;
    end
  end

endmodule

//--- hdl/roundRobinArbiter.sv
`timescale 1ns/100ps

module roundRobinArbiter
  import nocPkg::*;
  import arbPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portVec_t  reqs,
  input  flit_t     flitL,
  input  flit_t     flitN,
  input  flit_t     flitE,
  input  flit_t     flitW,
  input  flit_t     flitS,
  output arbState_e grant
);

  portVec_t  runTimer;
  portVec_t  timesUp;
  arbState_e nextGrant;

  // First requester in rotating order beginning at start.
  function automatic arbState_e firstReq(input portVec_t r, input portIdx_e start);
    logic [NumPorts-1:0] bits;
    int unsigned         idx;
    arbState_e           pick;
    bits = {r.s, r.w, r.e, r.n, r.l};
    pick = ArbIdle;
    // Walk from the farthest port inward so the nearest one wins.
    for (int i = NumPorts - 1; i >= 0; i--)
    begin
      idx = (int'(start) + i) % NumPorts;
      if (bits[idx])
      begin
        pick = arbState_e'(6'b000010 << idx);
      end
    end
    return pick;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Packet timers, one per input port.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  packetTimer timerL (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitL),
    .runTimer (runTimer.l),
    .timesUp  (timesUp.l)
  );

  packetTimer timerN (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitN),
    .runTimer (runTimer.n),
    .timesUp  (timesUp.n)
  );

  packetTimer timerE (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitE),
    .runTimer (runTimer.e),
    .timesUp  (timesUp.e)
  );

  packetTimer timerW (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitW),
    .runTimer (runTimer.w),
    .timesUp  (timesUp.w)
  );

  packetTimer timerS (
    .clk      (clk),
    .rst      (rst),
    .flit     (flitS),
    .runTimer (runTimer.s),
    .timesUp  (timesUp.s)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Grant FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    runTimer  = '0;
    nextGrant = ArbIdle;
    case (grant)
      ArbIdle:
        nextGrant = firstReq(reqs, PortL);
      GrantL:
        if (reqs.l && !timesUp.l)
        begin
          runTimer.l = 1'b1;
          nextGrant  = GrantL;
        end
        else
          nextGrant = firstReq(reqs, PortN);
      GrantN:
        if (reqs.n && !timesUp.n)
        begin
          runTimer.n = 1'b1;
          nextGrant  = GrantN;
        end
        else
          nextGrant = firstReq(reqs, PortE);
      GrantE:
        if (reqs.e && !timesUp.e)
        begin
          runTimer.e = 1'b1;
          nextGrant  = GrantE;
        end
        else
          nextGrant = firstReq(reqs, PortW);
      GrantW:
        if (reqs.w && !timesUp.w)
        begin
          runTimer.w = 1'b1;
          nextGrant  = GrantW;
        end
        else
          nextGrant = firstReq(reqs, PortS);
      GrantS:
        if (reqs.s && !timesUp.s)
        begin
          runTimer.s = 1'b1;
          nextGrant  = GrantS;
        end
        else
          nextGrant = firstReq(reqs, PortL);
      default:
        nextGrant = ArbIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= ArbIdle;
    else
      grant <= nextGrant;
  end

endmodule

//--- hdl/packetTimer.sv
`timescale 1ns/100ps

module packetTimer
  import nocPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flit_t flit,
  input  logic  runTimer,
  output logic  timesUp
);

  logic [11:0] limit;
  logic [11:0] count;

  // Limit follows every head flit on the port, granted or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flit.flitId == FlitHead)
      begin
        limit <= flit.length;
      end
      if (runTimer)
      begin
        count <= count + 12'd1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == limit);

endmodule

//--- hdl/arbPkg.sv
package arbPkg;

  import nocPkg::*;

  // One-hot grant state, one bit per port plus idle.
  typedef enum logic [5:0]
  {
    ArbIdle = 6'b000001,
    GrantL  = 6'b000010,
    GrantN  = 6'b000100,
    GrantE  = 6'b001000,
    GrantW  = 6'b010000,
    GrantS  = 6'b100000
  } arbState_e;

  // Per-port bits for requests, timer runs and times-up.
  typedef struct packed
  {
    logic l;
    logic n;
    logic e;
    logic w;
    logic s;
  } portVec_t;

  // Flits of all ports, element index follows portIdx_e.
  typedef flit_t [NumPorts-1:0] portFlits_t;

endpackage

//--- hdl/nocPkg.sv
package nocPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flit format.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0]
  {
    FlitIdle = 3'd0,
    FlitHead = 3'd1,
    FlitBody = 3'd2,
    FlitTail = 3'd3
  } flitId_e;

  // Length is only meaningful in a head flit.
  typedef struct packed
  {
    flitId_e     flitId;
    logic [11:0] length;
    logic [15:0] payload;
  } flit_t;

  localparam flit_t IdleFlit = '{flitId: FlitIdle, length: '0, payload: '0};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Router ports.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NumPorts = 5;

  typedef struct packed
  {
    logic  req;
    flit_t flit;
  } portIn_t;

  typedef enum logic [2:0]
  {
    PortL = 3'd0,
    PortN = 3'd1,
    PortE = 3'd2,
    PortW = 3'd3,
    PortS = 3'd4
  } portIdx_e;

endpackage
